// ==== sources.f ====
+incdir+include
verilog/blur_pkg.sv
verilog/blur_ctrl.sv
verilog/row_window.sv
verilog/conv_row.sv
verilog/gauss_blur_top.sv
dv/tb_gauss_blur.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gauss blur testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_gauss_blur \
  -f sources.f \
  -Mdir obj_dir \
  -o sim_gauss_blur

./obj_dir/sim_gauss_blur > sim.log 2>&1 || true
cat sim.log

# the log decides pass or fail
if grep -q "^TB PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== dv/tb_gauss_blur.sv ====
`include "blur_settings.svh"

module tb_gauss_blur;
  timeunit 1ns;
  timeprecision 100ps;

  import blur_pkg::*;

  localparam int IMG_ROWS    = `IMG_ROWS;
  localparam int IMG_COLS    = `IMG_COLS;
  localparam int ROW_PERIOD  = `ROW_PHASES;
  localparam int PIX_MAX     = (1 << `PIX_BITS) - 1;
  localparam int N_CASES     = 6;
  localparam int RESET_CYC   = 16;
  localparam int FRAME_CYC   = (IMG_ROWS + 2) * ROW_PERIOD;
  localparam int FRAME_LIMIT = 2 * FRAME_CYC;            // per-frame done timeout
  localparam int START_TO_DONE = FRAME_CYC + 2;          // clear cycle plus done cycle
  localparam int REPULSE_AT  = 40;                       // stray start mid frame
  localparam int WATCHDOG_CYC = N_CASES * FRAME_LIMIT + RESET_CYC;
  localparam logic [31:0] SEED = 32'h0eccc5df;

  // Q0.8 weights by absolute row and column offset
  localparam int W3 [2][2] = '{'{39, 30}, '{30, 24}};
  localparam int W5 [3][3] = '{'{16, 14, 10}, '{14, 13, 9}, '{10, 9, 6}};

  typedef enum int {PAT_FLAT, PAT_RANDOM, PAT_DOT, PAT_WHITE} pat_e;

  typedef struct {
    string  name;
    pat_e   kind;
    pixel_t fill;
    bit     sat;   // interior must clip
  } case_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     start;
  logic     done;
  row_addr_t img_addr;
  row_t     img_dout = '0;
  blur_wr_t blur3_wr;
  blur_wr_t blur5_wr;

  row_t  img_mem [2**`ROW_ADDR_BITS];  // rows past the image hold junk
  row_t  res3 [IMG_ROWS];             // captured 3x3 rows
  row_t  res5 [IMG_ROWS];             // captured 5x5 rows
  case_t cases [N_CASES];
  string cur_name = "reset";
  int    wr3_cnt = 0;
  int    wr5_cnt = 0;
  int    done_cnt = 0;
  int    done_cyc = 0;
  int    start_cyc = 0;
  int    cyc_now = 0;
  int    value_errs = 0;
  int    proto_errs = 0;
  logic [31:0] lcg_state;

  gauss_blur_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .img_addr (img_addr),
    .img_dout (img_dout),
    .blur3_wr (blur3_wr),
    .blur5_wr (blur5_wr)
  );

  always #20 clk = ~clk;  // 40 ns period

  // synchronous image memory returns data one cycle after the address
  always @(posedge clk) begin
    img_dout <= img_mem[img_addr];
  end

  // result memories and done monitor sampled mid cycle
  always @(negedge clk) begin
    cyc_now++;
    if (rst_n) begin
      if (blur3_wr.we) begin
        if (wr3_cnt < IMG_ROWS) begin
          check_addr($sformatf("%s wr3 addr", cur_name), row_addr_t'(wr3_cnt), blur3_wr.addr);
          res3[wr3_cnt] = blur3_wr.data;
        end
        wr3_cnt++;
      end
      if (blur5_wr.we) begin
        if (wr5_cnt < IMG_ROWS) begin
          check_addr($sformatf("%s wr5 addr", cur_name), row_addr_t'(wr5_cnt), blur5_wr.addr);
          res5[wr5_cnt] = blur5_wr.data;
        end
        wr5_cnt++;
      end
      if (done) begin
        done_cnt++;
        done_cyc = cyc_now;
        if (wr3_cnt != IMG_ROWS || wr5_cnt != IMG_ROWS) begin
          $display("%s: done came before all rows were written (3x3 %0d, 5x5 %0d)",
                   cur_name, wr3_cnt, wr5_cnt);
          proto_errs++;
        end
      end
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int tap_weight(input int ksize, input int adr, input int adc);
    if (ksize == 3) begin
      return W3[adr][adc];
    end
    return W5[adr][adc];
  endfunction

  // zero padded kernel sum, truncated and clipped
  function automatic pixel_t golden_pixel(input int ksize, input int r, input int c);
    int rad;
    int sum;
    int rr;
    int cc;
    rad = ksize / 2;
    sum = 0;
    for (int dr = -rad; dr <= rad; dr++) begin
      for (int dc = -rad; dc <= rad; dc++) begin
        rr = r + dr;
        cc = c + dc;
        if (rr >= 0 && rr < IMG_ROWS && cc >= 0 && cc < IMG_COLS) begin
          sum += tap_weight(ksize, (dr < 0) ? -dr : dr, (dc < 0) ? -dc : dc) *
                 int'(img_mem[rr][cc]);
        end
      end
    end
    sum = sum >> `COEF_FRAC;
    if (sum > PIX_MAX) begin
      sum = PIX_MAX;  // white clip
    end
    return pixel_t'(sum);
  endfunction

  function automatic row_t golden_row(input int ksize, input int r);
    row_t row;
    for (int c = 0; c < IMG_COLS; c++) begin
      row[c] = golden_pixel(ksize, r, c);
    end
    return row;
  endfunction

  task automatic check_row(input string name, input row_t exp, input row_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_addr(input string name, input row_addr_t exp, input row_addr_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic build_cases();
    cases[0] = '{"flat_100",   PAT_FLAT,   8'd100, 1'b0};
    cases[1] = '{"random_a",   PAT_RANDOM, 8'd0,   1'b0};
    cases[2] = '{"white",      PAT_WHITE,  8'd255, 1'b1};
    cases[3] = '{"corner_dot", PAT_DOT,    8'd255, 1'b0};  // follows white to show no residue
    cases[4] = '{"random_b",   PAT_RANDOM, 8'd0,   1'b0};
    cases[5] = '{"flat_7",     PAT_FLAT,   8'd7,   1'b0};
  endtask

  task automatic load_image(input case_t c);
    for (int r = 0; r < 2**`ROW_ADDR_BITS; r++) begin
      for (int col = 0; col < IMG_COLS; col++) begin
        img_mem[r][col] = pixel_t'((r * IMG_COLS + col) ^ 'h5a);  // junk the DUT must zero
      end
    end
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int col = 0; col < IMG_COLS; col++) begin
        case (c.kind)
          PAT_RANDOM: begin
            lcg_state = lcg_next(lcg_state);
            img_mem[r][col] = lcg_state[31:24];  // upper bits spread better
          end
          PAT_DOT: img_mem[r][col] = (r == 0 && col == 0) ? c.fill : '0;
          default: img_mem[r][col] = c.fill;     // flat and white
        endcase
      end
    end
  endtask

  // one frame with a stray start while it runs
  task automatic run_frame(input string name);
    int waited;
    cur_name = name;
    wr3_cnt = 0;
    wr5_cnt = 0;
    done_cnt = 0;
    for (int r = 0; r < IMG_ROWS; r++) begin
      res3[r] = '0;
      res5[r] = '0;
    end
    @(posedge clk);
    start <= 1'b1;
    start_cyc = cyc_now + 1;
    waited = 0;
    while (done_cnt == 0 && waited < FRAME_LIMIT) begin
      @(posedge clk);
      waited++;
      start <= (waited == REPULSE_AT);
    end
    if (done_cnt == 0) begin
      $display("%s: no done pulse within %0d cycles of start", name, FRAME_LIMIT);
      proto_errs++;
    end
    repeat (2 * ROW_PERIOD) @(posedge clk);  // any extra write or done shows here
  endtask

  task automatic score_frame(input case_t c);
    if (wr3_cnt != IMG_ROWS) begin
      $display("%s: 3x3 memory got %0d writes instead of %0d", c.name, wr3_cnt, IMG_ROWS);
      proto_errs++;
    end
    if (wr5_cnt != IMG_ROWS) begin
      $display("%s: 5x5 memory got %0d writes instead of %0d", c.name, wr5_cnt, IMG_ROWS);
      proto_errs++;
    end
    if (done_cnt != 1) begin
      $display("%s: done pulsed %0d times instead of once", c.name, done_cnt);
      proto_errs++;
    end else begin
      check_count($sformatf("%s latency", c.name), START_TO_DONE, done_cyc - start_cyc);
    end
    for (int r = 0; r < IMG_ROWS; r++) begin
      if (r < wr3_cnt) begin
        check_row($sformatf("%s 3x3 row %0d", c.name, r), golden_row(3, r), res3[r]);
      end
      if (r < wr5_cnt) begin
        check_row($sformatf("%s 5x5 row %0d", c.name, r), golden_row(5, r), res5[r]);
      end
    end
    if (c.sat) begin
      // 3x3 gives 255*255>>8 while the 5x5 weights sum past one and clip
      check_pixel($sformatf("%s 3x3 interior", c.name), 8'd254, res3[IMG_ROWS/2][IMG_COLS/2]);
      check_pixel($sformatf("%s 5x5 interior", c.name), 8'd255, res5[IMG_ROWS/2][IMG_COLS/2]);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    lcg_state = SEED;
    build_cases();
    repeat (RESET_CYC - 1) @(posedge clk);
    @(negedge clk);
    check_addr("reset img_addr", '0, img_addr);
    if (done || blur3_wr.we || blur5_wr.we) begin
      $display("reset: done or a write strobe is high during reset");
      proto_errs++;
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < N_CASES; i++) begin
      load_image(cases[i]);
      run_frame(cases[i].name);
      score_frame(cases[i]);
    end
    $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // hard stop if a frame never ends
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== verilog/gauss_blur_top.sv ====
module gauss_blur_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                done,
  output blur_pkg::row_addr_t img_addr,
  input  blur_pkg::row_t      img_dout,   // one cycle after img_addr
  output blur_pkg::blur_wr_t  blur3_wr,
  output blur_pkg::blur_wr_t  blur5_wr
);
  import blur_pkg::*;

  logic      clear;
  logic      shift;
  logic      zero_row;
  logic      calc;
  logic      wr3_we;
  logic      wr5_we;
  row_addr_t wr3_addr;
  row_addr_t wr5_addr;
  window_t   win;
  row_t      row3;  // 3x3 result
  row_t      row5;  // 5x5 result

  blur_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .img_addr (img_addr),
    .clear    (clear),
    .shift    (shift),
    .zero_row (zero_row),
    .calc     (calc),
    .wr3_we   (wr3_we),
    .wr5_we   (wr5_we),
    .wr3_addr (wr3_addr),
    .wr5_addr (wr5_addr)
  );

  row_window u_win (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .shift    (shift),
    .zero_row (zero_row),
    .img_dout (img_dout),
    .win      (win)
  );

  conv_row #(.KSIZE(3)) u_conv3 (
    .clk     (clk),
    .rst_n   (rst_n),
    .calc    (calc),
    .win     (win),
    .row_out (row3)
  );

  conv_row #(.KSIZE(5)) u_conv5 (
    .clk     (clk),
    .rst_n   (rst_n),
    .calc    (calc),
    .win     (win),
    .row_out (row5)
  );

  // strobe and address from the controller, data from the engines
  assign blur3_wr = '{we: wr3_we, addr: wr3_addr, data: row3};
  assign blur5_wr = '{we: wr5_we, addr: wr5_addr, data: row5};

endmodule

// ==== verilog/conv_row.sv ====
`include "blur_settings.svh"

module conv_row #(
  parameter int KSIZE = 3  // 3 or 5
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              calc,
  input  blur_pkg::window_t win,
  output blur_pkg::row_t    row_out
);
  import blur_pkg::*;

  localparam int RAD      = (KSIZE - 1) / 2;  // also the center row index
  localparam int ACC_BITS = `PIX_BITS + `COEF_BITS + $clog2(KSIZE * KSIZE);
  localparam logic [ACC_BITS-1:0] PIX_MAX = ACC_BITS'((1 << `PIX_BITS) - 1);

  row_t rows [`WIN_ROWS];  // window as indexable rows
  row_t row_nxt;

  for (genvar wi = 0; wi < `WIN_ROWS; wi++) begin : g_rows
    assign rows[wi] = win_row(win, wi);
  end

  // one MAC tree per output column
  for (genvar col = 0; col < `IMG_COLS; col++) begin : g_col
    logic [ACC_BITS-1:0] acc;
    logic [ACC_BITS-1:0] scaled;

    always_comb begin
      acc = '0;
      for (int i = 0; i < KSIZE; i++) begin
        for (int dc = -RAD; dc <= RAD; dc++) begin
          // left and right borders padded with zeros
          if ((col + dc >= 0) && (col + dc < `IMG_COLS)) begin
            acc = acc +
                  ACC_BITS'(kernel_weight(KSIZE,
                                          (i > RAD) ? i - RAD : RAD - i,
                                          (dc < 0) ? -dc : dc)) *
                  ACC_BITS'(rows[i][col + dc]);
          end
        end
      end
    end

    assign scaled = acc >> `COEF_FRAC;  // truncate the Q0.8 fraction
    // 5x5 weights sum past 1.0, clip at white
    assign row_nxt[col] = (scaled > PIX_MAX) ? '1 : pixel_t'(scaled);
  end

  // result held until the next calc
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_out <= '0;
    end else if (calc) begin
      row_out <= row_nxt;
    end
  end

endmodule

// ==== verilog/row_window.sv ====
module row_window (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              shift,
  input  logic              zero_row,
  input  blur_pkg::row_t    img_dout,
  output blur_pkg::window_t win
);
  import blur_pkg::*;

  row_t row_in;  // row entering at r0

  // drain rows pad the bottom border with zeros
  assign row_in = zero_row ? row_t'(0) : img_dout;

  // five rows deep, r0 newest
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win <= '0;
    end else if (clear) begin
      win <= '0;         // top border starts as zeros
    end else if (shift) begin
      win.r4 <= win.r3;  // oldest falls out
      win.r3 <= win.r2;
      win.r2 <= win.r1;  // 5x5 center
      win.r1 <= win.r0;  // 3x3 center
      win.r0 <= row_in;
    end
  end

endmodule

// ==== verilog/blur_ctrl.sv ====
`include "blur_settings.svh"

module blur_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                done,
  output blur_pkg::row_addr_t img_addr,
  output logic                clear,
  output logic                shift,
  output logic                zero_row,
  output logic                calc,
  output logic                wr3_we,
  output logic                wr5_we,
  output blur_pkg::row_addr_t wr3_addr,
  output blur_pkg::row_addr_t wr5_addr
);
  import blur_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CLEAR,  // one cycle, empties window and counters
    ST_RUN
  } state_t;

  // phase 0 presents img_addr, the rest idle
  localparam logic [`PHASE_BITS-1:0] PH_SHIFT = `PHASE_BITS'(1);  // window load
  localparam logic [`PHASE_BITS-1:0] PH_CALC  = `PHASE_BITS'(2);  // engines register
  localparam logic [`PHASE_BITS-1:0] PH_WRITE = `PHASE_BITS'(3);  // result strobes
  localparam logic [`PHASE_BITS-1:0] PH_LAST  = `PHASE_BITS'(`ROW_PHASES - 1);

  localparam row_addr_t ROW_ZERO = row_addr_t'(`IMG_ROWS);      // first drain row
  localparam row_addr_t ROW_LAST = row_addr_t'(`IMG_ROWS + 1);  // last drain row

  state_t                  state;
  state_t                  state_nxt;
  logic [`PHASE_BITS-1:0]  phase;    // position inside row period
  row_addr_t               row_cnt;  // k, 0 .. IMG_ROWS+1
  logic                    running;
  logic                    row_end;
  logic                    frame_end;

  assign running   = (state == ST_RUN);
  assign row_end   = running && (phase == PH_LAST);
  assign frame_end = row_end && (row_cnt == ROW_LAST);  // final period over

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_CLEAR;  // start only seen here
        end
      end
      ST_CLEAR: begin
        state_nxt = ST_RUN;
      end
      ST_RUN: begin
        if (frame_end) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // phase and row loop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase   <= '0;
      row_cnt <= '0;
    end else if (state == ST_CLEAR) begin
      phase   <= '0;
      row_cnt <= '0;
    end else if (running) begin
      if (frame_end) begin
        phase   <= '0;
        row_cnt <= '0;                     // idle address back to 0
      end else if (row_end) begin
        phase   <= '0;
        row_cnt <= row_cnt + row_addr_t'(1);
      end else begin
        phase   <= phase + `PHASE_BITS'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= frame_end;  // one cycle after last period
    end
  end

  // result address counters, each steps on its own strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr3_addr <= '0;
      wr5_addr <= '0;
    end else if (state == ST_CLEAR) begin
      wr3_addr <= '0;
      wr5_addr <= '0;
    end else begin
      if (wr3_we) begin
        wr3_addr <= wr3_addr + row_addr_t'(1);
      end
      if (wr5_we) begin
        wr5_addr <= wr5_addr + row_addr_t'(1);
      end
    end
  end

  assign img_addr = row_cnt;                              // memory answers next cycle
  assign clear    = (state == ST_CLEAR);
  assign shift    = running && (phase == PH_SHIFT);
  assign calc     = running && (phase == PH_CALC);
  assign zero_row = running && (row_cnt >= ROW_ZERO);     // drain rows past the image

  // 3x3 centered one row behind k, 5x5 two rows behind
  assign wr3_we = running && (phase == PH_WRITE) &&
                  (row_cnt >= row_addr_t'(1)) && (row_cnt <= ROW_ZERO);
  assign wr5_we = running && (phase == PH_WRITE) &&
                  (row_cnt >= row_addr_t'(2)) && (row_cnt <= ROW_LAST);

endmodule

// ==== verilog/blur_pkg.sv ====
`include "blur_settings.svh"

package blur_pkg;

  typedef logic [`PIX_BITS-1:0]      pixel_t;
  typedef pixel_t [`IMG_COLS-1:0]    row_t;       // column 0 in low bits
  typedef logic [`ROW_ADDR_BITS-1:0] row_addr_t;
  typedef logic [`COEF_BITS-1:0]     coef_t;

  typedef struct packed {
    row_t r4;  // oldest
    row_t r3;
    row_t r2;
    row_t r1;
    row_t r0;  // newest
  } window_t;

  typedef struct packed {
    logic      we;
    row_addr_t addr;
    row_t      data;
  } blur_wr_t;

  // symmetric Gaussian weights, Q0.8; dr and dc are absolute offsets
  function automatic coef_t kernel_weight(input int ksize, input int dr, input int dc);
    int far_off;
    int near_off;
    far_off  = (dr > dc) ? dr : dc;  // order the pair, kernel is symmetric
    near_off = (dr > dc) ? dc : dr;
    kernel_weight = '0;              // outside the kernel
    if (ksize == 3) begin
      case (far_off + near_off)
        0:       kernel_weight = 8'd39;  // center
        1:       kernel_weight = 8'd30;  // edge
        2:       kernel_weight = 8'd24;  // corner
        default: kernel_weight = '0;
      endcase
    end else if (ksize == 5) begin
      if (far_off == 2) begin
        kernel_weight = (near_off == 2) ? 8'd6 : (near_off == 1) ? 8'd9 : 8'd10;
      end else if (far_off == 1) begin
        kernel_weight = (near_off == 1) ? 8'd13 : 8'd14;
      end else if (far_off == 0) begin
        kernel_weight = 8'd16;
      end
    end
  endfunction

  // window row by index, 0 newest
  function automatic row_t win_row(input window_t w, input int idx);
    case (idx)
      0:       win_row = w.r0;
      1:       win_row = w.r1;
      2:       win_row = w.r2;
      3:       win_row = w.r3;
      default: win_row = w.r4;
    endcase
  endfunction

endpackage

// ==== include/blur_settings.svh ====
`ifndef BLUR_SETTINGS_SVH
`define BLUR_SETTINGS_SVH

// image geometry
`define IMG_COLS       16   // pixels per row
`define IMG_ROWS       8    // rows per frame
`define PIX_BITS       8    // grayscale depth

// row addressing, covers IMG_ROWS plus the two drain rows
`define ROW_ADDR_BITS  4

// per-row schedule
`define ROW_PHASES     10   // cycles per row period
`define PHASE_BITS     4    // phase counter width

// sliding window depth, enough for the 5x5 kernel
`define WIN_ROWS       5

// kernel weights
`define COEF_BITS      8    // stored weight width
`define COEF_FRAC      8    // Q0.8, sum shifted down by this

`endif
